//--- include/tiny_cpu_config.svh
`ifndef TINY_CPU_CONFIG_SVH
`define TINY_CPU_CONFIG_SVH

// Data and instruction bytes
`define DATA_W 8

// 256-byte memory
`define ADDR_W 8

// Opcode layout is class[7:6] dst[5:3] src[2:0]
`define CLASS_MSB 7
`define DST_LSB   3
`define SRC_LSB   0

`endif

//--- design/tiny_cpu_pkg.sv
package tiny_cpu_pkg;

  typedef enum logic [2:0] {
    RESET_STAGE, FETCH_OP, DECODE, FETCH_OPERANDS,
    EXECUTE, WRITE_REG, WRITE_MEM, HALTED
  } stage_t;

  typedef enum logic [3:0] {
    MOV, ADD, CMP, JMP, JC, JNC, JZ, JNZ, NOP, HLT
  } op_t;

  typedef enum logic [1:0] {
    UNUSED, REG_A, IMM, ADDR_IMM
  } operand_t;

  // Read currently on the bus during FETCH_OPERANDS
  typedef enum logic [2:0] {
    NONE, IMM_VAL, SRC_ADDR, SRC_DATA, DST_ADDR, DST_DATA
  } read_item_t;

  typedef enum logic [1:0] {
    STAY, READ, WRITE
  } bus_cmd_t;

  typedef struct packed {
    op_t      op;
    operand_t src_kind;
    operand_t dst_kind;
  } decoded_t;

endpackage

//--- design/operand_if.sv
`include "tiny_cpu_config.svh"

// Bytes gathered during FETCH_OPERANDS
interface operand_if;
  logic [`DATA_W-1:0] imm;
  logic [`ADDR_W-1:0] src_addr;
  logic [`DATA_W-1:0] src_data;
  logic [`ADDR_W-1:0] dst_addr;
  logic [`DATA_W-1:0] dst_data;

  modport producer (
    output imm, src_addr, src_data, dst_addr, dst_data
  );

  modport consumer (
    input imm, src_addr, src_data, dst_addr, dst_data
  );
endinterface

//--- design/sequencer.sv
module sequencer import tiny_cpu_pkg::*; (
  input    logic       CLOCK
  , input  logic       RESET
  , input  decoded_t   dec
  , output stage_t     stage
  , output read_item_t read_item
  , output logic       capture
  , output logic       halted
);

  stage_t     state, next_state;
  read_item_t done, next_done;
  logic       phase, next_phase;
  logic       stores;

  // Reads go immediate, source address and data, then destination
  function automatic read_item_t plan_read(input read_item_t last, input decoded_t d);
    read_item_t dst_step;
    dst_step = (d.dst_kind == ADDR_IMM) ? DST_ADDR : NONE;
    case (last)
      NONE: begin
        case (d.src_kind)
          IMM:      return IMM_VAL;
          ADDR_IMM: return SRC_ADDR;
          default:  return dst_step;
        endcase
      end
      SRC_ADDR:          return SRC_DATA;
      DST_ADDR:          return DST_DATA;
      IMM_VAL, SRC_DATA: return dst_step;
      default:           return NONE;
    endcase
  endfunction

  assign read_item = (state == FETCH_OPERANDS) ? plan_read(done, dec) : NONE;
  // Operand stage with nothing left to read is the execute cycle
  assign stage   = (state == FETCH_OPERANDS && read_item == NONE) ? EXECUTE : state;
  assign capture = phase;
  assign halted  = (state == HALTED);
  // CMP never writes its result back
  assign stores  = (dec.dst_kind == ADDR_IMM) && (dec.op inside {MOV, ADD});

  always_comb begin
    next_state = state;
    next_done  = done;
    next_phase = 1'b0;
    case (state)
      RESET_STAGE: next_state = FETCH_OP;
      FETCH_OP: begin
        next_phase = !phase;
        next_state = phase ? DECODE : FETCH_OP;
      end
      DECODE: begin
        next_state = FETCH_OPERANDS;
        next_done  = NONE;
      end
      FETCH_OPERANDS: begin
        if (read_item != NONE) begin
          next_phase = !phase;
          next_done  = phase ? read_item : done;
        end else begin
          next_state = (dec.op == HLT) ? HALTED : WRITE_REG;
        end
      end
      WRITE_REG: next_state = stores ? WRITE_MEM : FETCH_OP;
      WRITE_MEM: next_state = FETCH_OP;
      default:   next_state = HALTED;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      state <= RESET_STAGE;
      done  <= NONE;
      phase <= 1'b0;
    end else begin
      state <= next_state;
      done  <= next_done;
      phase <= next_phase;
    end
  end

  // Every read is one address cycle then one capture cycle in the same stage
  assert property (@(posedge CLOCK) disable iff (RESET)
    capture |-> (stage inside {FETCH_OP, FETCH_OPERANDS})
      && stage == $past(stage) && !$past(capture));

endmodule

//--- design/program_counter.sv
`include "tiny_cpu_config.svh"

module program_counter import tiny_cpu_pkg::*; (
  input    logic       CLOCK
  , input  logic       RESET
  , input  stage_t     stage
  , input  read_item_t read_item
  , input  logic       capture
  , input  decoded_t   dec
  , operand_if.consumer operands
  , input  logic       carry
  , input  logic       zero
  , output logic [`DATA_W-1:0] ip
);

  logic taken;
  logic step;

  always_comb begin
    case (dec.op)
      JMP:     taken = 1'b1;
      JC:      taken = carry;
      JNC:     taken = !carry;
      JZ:      taken = zero;
      JNZ:     taken = !zero;
      default: taken = 1'b0;
    endcase
  end

  // Instruction, immediate and address bytes sit in the ip stream
  assign step = capture
    && (stage == FETCH_OP || read_item inside {IMM_VAL, SRC_ADDR, DST_ADDR});

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      ip <= '0;
    end else if (step) begin
      ip <= ip + `DATA_W'(1);
    end else if (stage == EXECUTE && taken) begin
      // offset counts from the byte after the jump
      ip <= ip + operands.imm;
    end
  end

  assert property (@(posedge CLOCK) disable iff (RESET)
    stage == HALTED |=> ip == $past(ip));

endmodule

//--- design/decoder.sv
`include "tiny_cpu_config.svh"

module decoder import tiny_cpu_pkg::*; (
  input    logic     CLOCK
  , input  logic     RESET
  , input  stage_t   stage
  , input  logic     capture
  , input  logic [`DATA_W-1:0] read_bus
  , output decoded_t dec
);

  logic [`DATA_W-1:0] opcode;
  logic [1:0]         op_class;
  logic [2:0]         dst_field;
  logic [2:0]         src_field;
  decoded_t           next_dec;

  assign op_class  = opcode[`CLASS_MSB -: 2];
  assign dst_field = opcode[`DST_LSB +: 3];
  assign src_field = opcode[`SRC_LSB +: 3];

  // 000 is A, 010 a direct address, 011 an immediate
  function automatic operand_t field_kind(input logic [2:0] field);
    case (field)
      3'b000:  return REG_A;
      3'b010:  return ADDR_IMM;
      3'b011:  return IMM;
      default: return UNUSED;
    endcase
  endfunction

  always_comb begin
    next_dec = '{op: HLT, src_kind: UNUSED, dst_kind: UNUSED};
    if (op_class != 2'b11) begin
      // Destination IMM and the unused codes stay HLT
      if (field_kind(src_field) != UNUSED && field_kind(dst_field) inside {REG_A, ADDR_IMM}) begin
        case (op_class)
          2'b00:   next_dec.op = MOV;
          2'b01:   next_dec.op = ADD;
          default: next_dec.op = CMP;
        endcase
        next_dec.src_kind = field_kind(src_field);
        next_dec.dst_kind = field_kind(dst_field);
      end
    end else begin
      case ({dst_field, src_field})
        6'b010_000: next_dec.op = JMP;
        6'b100_010: next_dec.op = JC;
        6'b100_011: next_dec.op = JNC;
        6'b100_100: next_dec.op = JZ;
        6'b100_101: next_dec.op = JNZ;
        6'b111_110: next_dec.op = NOP;
        default:    next_dec.op = HLT;
      endcase
      // Jumps carry their offset as an immediate
      if (next_dec.op inside {JMP, JC, JNC, JZ, JNZ}) begin
        next_dec.src_kind = IMM;
      end
    end
  end

  always_ff @(posedge CLOCK) begin
    if (stage == FETCH_OP && capture) begin
      opcode <= read_bus;
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      dec <= '{op: NOP, src_kind: UNUSED, dst_kind: UNUSED};
    end else if (stage == DECODE) begin
      dec <= next_dec;
    end
  end

endmodule

//--- design/operand_fetch.sv
`include "tiny_cpu_config.svh"

module operand_fetch import tiny_cpu_pkg::*; (
  input    logic       CLOCK
  , input  logic       RESET
  , input  read_item_t read_item
  , input  logic       capture
  , input  logic [`DATA_W-1:0] read_bus
  , operand_if.producer operands
);

  // One register per read kind, loaded on its capture edge
  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      operands.imm      <= '0;
      operands.src_addr <= '0;
      operands.src_data <= '0;
      operands.dst_addr <= '0;
      operands.dst_data <= '0;
    end else if (capture) begin
      case (read_item)
        IMM_VAL:  operands.imm      <= read_bus;
        SRC_ADDR: operands.src_addr <= read_bus;
        SRC_DATA: operands.src_data <= read_bus;
        DST_ADDR: operands.dst_addr <= read_bus;
        DST_DATA: operands.dst_data <= read_bus;
        default:  ;
      endcase
    end
  end

endmodule

//--- design/alu_regs.sv
`include "tiny_cpu_config.svh"

module alu_regs import tiny_cpu_pkg::*; (
  input    logic     CLOCK
  , input  logic     RESET
  , input  stage_t   stage
  , input  decoded_t dec
  , operand_if.consumer operands
  , output logic [`DATA_W-1:0] result
  , output logic     carry
  , output logic     zero
  , output logic [`DATA_W-1:0] acc
);

  logic [`DATA_W-1:0] src_val;
  logic [`DATA_W-1:0] dst_val;
  logic [`DATA_W:0]   sum;
  logic [`DATA_W:0]   diff;
  logic               res_carry;
  logic               res_zero;

  always_comb begin
    case (dec.src_kind)
      REG_A:    src_val = acc;
      IMM:      src_val = operands.imm;
      ADDR_IMM: src_val = operands.src_data;
      default:  src_val = '0;
    endcase
    dst_val = (dec.dst_kind == ADDR_IMM) ? operands.dst_data : acc;
  end

  // Top bit of diff is the borrow, set when dst < src
  assign sum  = {1'b0, dst_val} + {1'b0, src_val};
  assign diff = {1'b0, dst_val} - {1'b0, src_val};

  always_ff @(posedge CLOCK) begin
    if (stage == EXECUTE) begin
      case (dec.op)
        MOV: result <= src_val;
        ADD: begin
          result    <= sum[`DATA_W-1:0];
          res_carry <= sum[`DATA_W];
          res_zero  <= (sum[`DATA_W-1:0] == '0);
        end
        CMP: begin
          res_carry <= diff[`DATA_W];
          res_zero  <= (diff[`DATA_W-1:0] == '0);
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      acc   <= '0;
      carry <= 1'b0;
      zero  <= 1'b0;
    end else if (stage == WRITE_REG) begin
      if (dec.dst_kind == REG_A && dec.op inside {MOV, ADD}) begin
        acc <= result;
      end
      if (dec.op inside {ADD, CMP}) begin
        carry <= res_carry;
        zero  <= res_zero;
      end
    end
  end

endmodule

//--- design/memory_port.sv
`include "tiny_cpu_config.svh"

module memory_port import tiny_cpu_pkg::*; (
  input    logic       CLOCK
  , input  logic       RESET
  , input  stage_t     stage
  , input  read_item_t read_item
  , input  logic [`DATA_W-1:0] ip
  , input  decoded_t   dec
  , input  logic [`DATA_W-1:0] result
  , operand_if.consumer operands
  , output logic [`ADDR_W-1:0] addr_bus
  , output bus_cmd_t   ctrl_bus
  , output logic [`DATA_W-1:0] write_bus
);

  always_comb begin
    case (stage)
      FETCH_OP: addr_bus = ip;
      FETCH_OPERANDS: begin
        case (read_item)
          SRC_DATA: addr_bus = operands.src_addr;
          DST_DATA: addr_bus = operands.dst_addr;
          default:  addr_bus = ip;
        endcase
      end
      WRITE_MEM: addr_bus = operands.dst_addr;
      default:   addr_bus = '0;
    endcase
  end

  always_comb begin
    case (stage)
      FETCH_OP, FETCH_OPERANDS: ctrl_bus = READ;
      WRITE_MEM:                ctrl_bus = WRITE;
      default:                  ctrl_bus = STAY;
    endcase
  end

  always_ff @(posedge CLOCK) begin
    if (RESET) begin
      write_bus <= '0;
    end else if (stage == WRITE_REG && dec.dst_kind == ADDR_IMM) begin
      write_bus <= result;
    end
  end

  // Stores only follow the WRITE_REG of a MOV or ADD to memory
  assert property (@(posedge CLOCK) disable iff (RESET)
    ctrl_bus == WRITE |-> $past(stage) == WRITE_REG
      && dec.dst_kind == ADDR_IMM && dec.op inside {MOV, ADD});

endmodule

//--- design/tiny_cpu.sv
`include "tiny_cpu_config.svh"

module tiny_cpu import tiny_cpu_pkg::*; (
  input    logic     CLOCK
  , input  logic     RESET
  , input  logic [`DATA_W-1:0] read_bus
  , output logic [`ADDR_W-1:0] addr_bus
  , output logic [`DATA_W-1:0] write_bus
  , output bus_cmd_t ctrl_bus
  , output logic [`DATA_W-1:0] acc_out
  , output logic     halted
);

  stage_t             stage;
  read_item_t         read_item;
  logic               capture;
  decoded_t           dec;
  logic [`DATA_W-1:0] ip;
  logic [`DATA_W-1:0] result;
  logic               carry;
  logic               zero;

  operand_if operands ();

  sequencer sequencer_i (
    .CLOCK, .RESET, .dec, .stage, .read_item, .capture, .halted
  );

  program_counter program_counter_i (
    .CLOCK, .RESET, .stage, .read_item, .capture, .dec,
    .operands(operands.consumer), .carry, .zero, .ip
  );

  decoder decoder_i (
    .CLOCK, .RESET, .stage, .capture, .read_bus, .dec
  );

  operand_fetch operand_fetch_i (
    .CLOCK, .RESET, .read_item, .capture, .read_bus, .operands(operands.producer)
  );

  alu_regs alu_regs_i (
    .CLOCK, .RESET, .stage, .dec, .operands(operands.consumer),
    .result, .carry, .zero, .acc(acc_out)
  );

  memory_port memory_port_i (
    .CLOCK, .RESET, .stage, .read_item, .ip, .dec, .result,
    .operands(operands.consumer), .addr_bus, .ctrl_bus, .write_bus
  );

endmodule

//--- sim/tiny_cpu_tb.sv
`include "tiny_cpu_config.svh"

module tiny_cpu_tb import tiny_cpu_pkg::*; ();

  localparam logic [7:0] mov_a_imm   = 8'h03;
  localparam logic [7:0] add_a_imm   = 8'h43;
  localparam logic [7:0] add_a_mem   = 8'h42;
  localparam logic [7:0] mov_mem_a   = 8'h10;
  localparam logic [7:0] mov_mem_imm = 8'h13;
  localparam logic [7:0] add_mem_imm = 8'h53;
  localparam logic [7:0] cmp_a_imm   = 8'h83;
  localparam logic [7:0] jc          = 8'he2;
  localparam logic [7:0] jnc         = 8'he3;
  localparam logic [7:0] jz          = 8'he4;
  localparam logic [7:0] jnz         = 8'he5;
  localparam logic [7:0] nop         = 8'hfe;
  localparam logic [7:0] hlt         = 8'hff;
  // MOV with an immediate as destination
  localparam logic [7:0] dst_imm     = 8'h18;

  logic               CLOCK;
  logic               RESET;
  logic [`DATA_W-1:0] read_bus;
  logic [`ADDR_W-1:0] addr_bus;
  logic [`DATA_W-1:0] write_bus;
  bus_cmd_t           ctrl_bus;
  logic [`DATA_W-1:0] acc_out;
  logic               halted;

  logic [`DATA_W-1:0]        mem [1 << `ADDR_W];
  logic [`DATA_W-1:0]        wr_val [1 << `ADDR_W];
  logic [(1 << `ADDR_W)-1:0] wr_ok;
  logic [`ADDR_W-1:0]        load_ptr;
  logic [7:0]                marker_expect;
  logic [7:0]                exp_acc;
  logic [7:0]                acc_expect;
  logic [31:0]               lcg_state;
  logic reset_window;
  logic first_read;
  logic halt_hold;
  logic acc_check;
  int   write_total;
  int   writes_before;
  int   exp_writes;
  int   errors;
  int   errors_before;
  int   tests;
  int   failed;

  tiny_cpu dut_i (
    .CLOCK, .RESET, .read_bus, .addr_bus, .write_bus, .ctrl_bus, .acc_out, .halted
  );

  // Memory answers reads at once and stores on the edge
  assign read_bus = mem[addr_bus];

  always @(posedge CLOCK) begin
    if (ctrl_bus == WRITE) begin
      mem[addr_bus] = write_bus;
      write_total++;
    end
  end

  initial begin
    CLOCK = 1'b0;
    forever #20 CLOCK = ~CLOCK;
  end

  assign acc_expect = reset_window ? 8'h00 : exp_acc;

  assert property (@(posedge CLOCK) reset_window || (acc_check && halted) |-> acc_out == acc_expect)
    else report_mismatch("acc_out", $sampled(acc_expect), $sampled(acc_out));
  assert property (@(posedge CLOCK) reset_window || halt_hold |-> ctrl_bus == STAY)
    else report_mismatch("ctrl_bus", 8'(STAY), 8'($sampled(ctrl_bus)));
  assert property (@(posedge CLOCK) reset_window || halt_hold |-> halted == halt_hold)
    else report_mismatch("halted", 8'($sampled(halt_hold)), 8'($sampled(halted)));
  assert property (@(posedge CLOCK) first_read && ctrl_bus == READ |-> addr_bus == '0)
    else report_mismatch("addr_bus", 8'h00, $sampled(addr_bus));
  assert property (@(posedge CLOCK) ctrl_bus == WRITE |-> wr_ok[addr_bus])
    else begin
      $display("unexpected write of %02h to address %02h at %0t",
               $sampled(write_bus), $sampled(addr_bus), $time);
      errors++;
    end
  assert property (@(posedge CLOCK)
    ctrl_bus == WRITE && wr_ok[addr_bus] |-> write_bus == wr_val[addr_bus])
    else report_mismatch("write_bus", wr_val[$sampled(addr_bus)], $sampled(write_bus));

  function automatic logic [7:0] random_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic report_mismatch(input string name, input logic [7:0] expected,
                                 input logic [7:0] actual);
    $display("MISMATCH at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic begin_test();
    for (int i = 0; i < (1 << `ADDR_W); i++) begin
      mem[`ADDR_W'(i)] = `DATA_W'(i) ^ 8'h5a;
    end
    wr_ok = '0;
    load_ptr = '0;
    marker_expect = '0;
    exp_writes = 0;
    writes_before = write_total;
    errors_before = errors;
  endtask

  task automatic emit_byte(input logic [7:0] value);
    mem[load_ptr] = value;
    load_ptr = load_ptr + 1'b1;
  endtask

  task automatic emit_pair(input logic [7:0] opcode, input logic [7:0] arg);
    emit_byte(opcode);
    emit_byte(arg);
  endtask

  task automatic expect_write(input logic [7:0] addr, input logic [7:0] value);
    wr_ok[addr] = 1'b1;
    wr_val[addr] = value;
    exp_writes++;
  endtask

  // Marker k stores a0+k at f0+k
  task automatic emit_marker(input logic [2:0] k, input logic store);
    logic [7:0] addr;
    addr = 8'hf0 + 8'(k);
    emit_pair(mov_mem_imm, 8'ha0 + 8'(k));
    emit_byte(addr);
    mem[addr] = 8'h00;
    marker_expect[k] = store;
    if (store) begin
      expect_write(addr, 8'ha0 + 8'(k));
    end
  endtask

  task automatic check_markers();
    logic [7:0] addr;
    logic [7:0] want;
    for (int k = 1; k <= 5; k++) begin
      addr = 8'hf0 + 8'(k);
      want = marker_expect[3'(k)] ? 8'ha0 + 8'(k) : 8'h00;
      assert (mem[addr] == want)
        else report_mismatch($sformatf("mem[%02h]", addr), want, mem[addr]);
    end
  endtask

  task automatic run_program(input logic [7:0] expected);
    int cycles;
    @(posedge CLOCK);
    #1;
    acc_check = 1'b0;
    halt_hold = 1'b0;
    RESET = 1'b1;
    @(posedge CLOCK);
    #1 reset_window = 1'b1;
    repeat (9) @(posedge CLOCK);
    #1;
    RESET = 1'b0;
    first_read = 1'b1;
    exp_acc = expected;
    acc_check = 1'b1;
    // RESET_STAGE cycle still counts as reset
    @(posedge CLOCK);
    #1 reset_window = 1'b0;
    cycles = 0;
    while (ctrl_bus != READ && cycles < 4) begin
      @(posedge CLOCK);
      #1 cycles++;
    end
    if (ctrl_bus != READ) begin
      $display("no memory read issued after reset at %0t", $time);
      errors++;
    end
    @(posedge CLOCK);
    #1 first_read = 1'b0;
    cycles = 0;
    while (!halted && cycles < 1000) begin
      @(posedge CLOCK);
      #1 cycles++;
    end
    if (!halted) begin
      $display("timeout: halted did not rise within 1000 cycles at %0t", $time);
      errors++;
    end else begin
      halt_hold = 1'b1;
      repeat (16) @(posedge CLOCK);
      #1 halt_hold = 1'b0;
    end
  endtask

  task automatic end_test(input string name);
    assert (write_total - writes_before == exp_writes)
      else begin
        $display("MISMATCH at %0t: write count expected %0d, got %0d", $time, exp_writes,
                 write_total - writes_before);
        errors++;
      end
    tests++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      failed++;
      $display("test %s: %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic sum_test();
    logic [7:0] r0, r1, r2, addr;
    begin_test();
    r0 = random_byte();
    r1 = random_byte();
    r2 = random_byte();
    addr = 8'h80 | random_byte();
    mem[addr] = r2;
    emit_pair(mov_a_imm, r0);
    emit_pair(add_a_imm, r1);
    emit_pair(add_a_mem, addr);
    emit_byte(hlt);
    run_program(r0 + r1 + r2);
    end_test("sum");
  endtask

  task automatic store_test();
    logic [7:0] r0, r1, r2, low;
    begin_test();
    r0 = random_byte();
    r1 = random_byte();
    r2 = random_byte();
    low = random_byte() & 8'h3f;
    mem[8'hc0 | low] = r2;
    expect_write(8'h80 | low, r0);
    expect_write(8'hc0 | low, r2 + r1);
    emit_pair(mov_a_imm, r0);
    emit_pair(mov_mem_a, 8'h80 | low);
    emit_pair(add_mem_imm, r1);
    emit_byte(8'hc0 | low);
    emit_byte(hlt);
    run_program(r0);
    end_test("store");
  endtask

  // Each taken jump skips the three-byte marker after it
  task automatic branch_test(input logic [7:0] x, input logic [7:0] y, input string name);
    logic [7:0] a, b;
    begin_test();
    a = 8'h80 | random_byte();
    b = 8'h80 | random_byte();
    emit_pair(mov_a_imm, x);
    emit_pair(cmp_a_imm, y);
    emit_pair(jz, 8'd3);
    emit_marker(3'd1, x != y);
    emit_pair(jnz, 8'd3);
    emit_marker(3'd2, x == y);
    emit_pair(jc, 8'd3);
    emit_marker(3'd3, x >= y);
    emit_pair(jnc, 8'd3);
    emit_marker(3'd4, x < y);
    // Two bytes with the top bit set always carry out
    emit_pair(mov_a_imm, a);
    emit_pair(add_a_imm, b);
    emit_pair(jc, 8'd3);
    emit_marker(3'd5, 1'b0);
    emit_byte(hlt);
    run_program(a + b);
    check_markers();
    end_test(name);
  endtask

  initial begin
    logic [7:0] x, y, r;
    RESET = 1'b1;
    reset_window = 1'b0;
    first_read = 1'b0;
    halt_hold = 1'b0;
    acc_check = 1'b0;
    exp_acc = 8'h00;
    lcg_state = 32'h0c177c8c;
    errors = 0;
    tests = 0;
    failed = 0;
    begin_test();
    emit_byte(hlt);
    run_program(8'h00);
    end_test("reset");
    sum_test();
    store_test();
    x = random_byte();
    y = random_byte();
    if (x == y) begin
      y = x ^ 8'h01;
    end
    branch_test(x, x, "branch equal");
    branch_test((x < y) ? x : y, (x < y) ? y : x, "branch lower");
    branch_test((x < y) ? y : x, (x < y) ? x : y, "branch higher");
    begin_test();
    emit_byte(nop);
    emit_byte(hlt);
    run_program(8'h00);
    end_test("halt");
    begin_test();
    r = random_byte();
    emit_pair(mov_a_imm, r);
    emit_byte(dst_imm);
    emit_pair(mov_a_imm, ~r);
    emit_byte(hlt);
    run_program(r);
    end_test("illegal");
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- tiny_cpu.f
+incdir+include
design/tiny_cpu_pkg.sv
design/operand_if.sv
design/sequencer.sv
design/program_counter.sv
design/decoder.sv
design/operand_fetch.sv
design/alu_regs.sv
design/memory_port.sv
design/tiny_cpu.sv
sim/tiny_cpu_tb.sv

//--- Makefile
TOP := tiny_cpu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tiny_cpu.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f tiny_cpu.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
